//--- glb_pkg.sv
`default_nettype none

package glb_pkg;

    // ====================
    // Default top-level parameters
    // ====================
    localparam int DEF_NUM_BANK   = 8;
    localparam int DEF_BANK_WIDTH = 16;
    // Must be a power of two
    localparam int DEF_BANK_DEPTH = 16;
    localparam int DEF_ADDR_WIDTH = 8;
    localparam int DEF_NUM_WRPORT = 2;
    localparam int DEF_NUM_RDPORT = 2;
    localparam int DEF_MAXPAR     = 2;

    // ====================
    // Derived widths
    // ====================
    localparam int BANK_IDX_W = $clog2(DEF_NUM_BANK);
    localparam int PAR_W      = $clog2(DEF_MAXPAR) + 1;
    localparam int PORT_W     = DEF_MAXPAR * DEF_BANK_WIDTH;

    // One bank row
    typedef logic [DEF_BANK_WIDTH-1:0] bank_data_t;

    // One port word, MAXPAR lanes
    typedef logic [PORT_W-1:0] port_data_t;

    // Port address, also used for the level registers
    typedef logic [DEF_ADDR_WIDTH-1:0] gaddr_t;

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    // Parallel bank count, 0 to MAXPAR
    typedef logic [PAR_W-1:0] par_t;

endpackage

`default_nettype wire

//--- glb_port_map.sv
`timescale 1ns/1ns
`default_nettype none

module glb_port_map
    import glb_pkg::*;
#(
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
) (
    input  logic [NUM_BANK-1:0] cfg_flag_i,
    input  par_t                cfg_par_i,
    input  gaddr_t              addr_i,
    output logic                alloc_o,
    output bank_idx_t           hit_bank_o,
    output logic [NUM_BANK-1:0] hit_mask_o,
    output gaddr_t              range_o
);

    localparam int ROW_W = $clog2(BANK_DEPTH);

    bank_idx_t   first_bank;
    int unsigned num_banks;
    int unsigned par_eff;
    int unsigned range_int;
    int unsigned group;
    int unsigned hit_int;

    assign alloc_o = |cfg_flag_i;

    // Priority select of the lowest owned bank
    always_comb begin
        first_bank = '0;
        for (int i = NUM_BANK - 1; i >= 0; i--) begin
            if (cfg_flag_i[i]) begin
                first_bank = bank_idx_t'(i);
            end
        end
    end

    // Popcount of the bank mask
    always_comb begin
        num_banks = 0;
        for (int i = 0; i < NUM_BANK; i++) begin
            num_banks = num_banks + int'(cfg_flag_i[i]);
        end
    end

    // ====================
    // Ring mapping
    // ====================
    always_comb begin
        if (cfg_par_i == '0) begin
            par_eff = 1;
        end else begin
            par_eff = int'(cfg_par_i);
        end
        // Unallocated port falls back to one bank of depth
        range_int = alloc_o ? (BANK_DEPTH * num_banks) / par_eff : BANK_DEPTH;
        group     = (int'(addr_i) % range_int) >> ROW_W;
        hit_int   = int'(first_bank) + group * par_eff;
    end

    assign hit_bank_o = bank_idx_t'(hit_int);
    assign range_o    = gaddr_t'(range_int);

    // PAR adjacent banks starting at the hit bank
    always_comb begin
        for (int unsigned b = 0; b < NUM_BANK; b++) begin
            hit_mask_o[b] = (b >= hit_int) && (b < hit_int + int'(cfg_par_i));
        end
    end

endmodule

`default_nettype wire

//--- glb_wr_port.sv
`timescale 1ns/1ns
`default_nettype none

module glb_wr_port
    import glb_pkg::*;
#(
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
) (
    input  logic                wr_vld_i,
    input  gaddr_t              wr_addr_i,
    input  logic [NUM_BANK-1:0] cfg_flag_i,
    input  par_t                cfg_par_i,
    input  gaddr_t              bank_rd_level_i [NUM_BANK],
    output logic                wr_rdy_o,
    output logic                full_o,
    output logic [NUM_BANK-1:0] bank_wen_o,
    output bank_idx_t           hit_bank_o
);

    logic                alloc;
    logic [NUM_BANK-1:0] hit_mask;
    gaddr_t              range;
    gaddr_t              used;

    glb_port_map #(
        .NUM_BANK   (NUM_BANK),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_map (
        .cfg_flag_i (cfg_flag_i),
        .cfg_par_i  (cfg_par_i),
        .addr_i     (wr_addr_i),
        .alloc_o    (alloc),
        .hit_bank_o (hit_bank_o),
        .hit_mask_o (hit_mask),
        .range_o    (range)
    );

    // Words ahead of the reader, wraps modulo 2**ADDR_WIDTH
    assign used   = wr_addr_i - bank_rd_level_i[hit_bank_o];
    assign full_o = used >= range;

    // Banks always take a write, so only full holds the port off
    assign wr_rdy_o = alloc & ~full_o;

    assign bank_wen_o = hit_mask & {NUM_BANK{wr_vld_i & wr_rdy_o}};

endmodule

`default_nettype wire

//--- glb_rd_port.sv
`timescale 1ns/1ns
`default_nettype none

module glb_rd_port
    import glb_pkg::*;
#(
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int MAXPAR     = DEF_MAXPAR
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_addr_vld_i,
    input  gaddr_t              rd_addr_i,
    input  logic [NUM_BANK-1:0] cfg_flag_i,
    input  par_t                cfg_par_i,
    input  gaddr_t              bank_wr_level_i [NUM_BANK],
    input  logic [NUM_BANK-1:0] bank_free_i,
    input  logic [NUM_BANK-1:0] bank_rvalid_i,
    input  bank_data_t          bank_rdata_i [NUM_BANK],
    input  logic                rd_dat_rdy_i,
    output logic                rd_addr_rdy_o,
    output logic                empty_o,
    output logic [NUM_BANK-1:0] bank_ren_o,
    output port_data_t          rd_dat_o,
    output logic                rd_dat_vld_o,
    output bank_idx_t           hit_bank_o
);

    logic                alloc;
    logic [NUM_BANK-1:0] hit_mask;
    logic                addr_hs;
    logic                dat_hs;
    logic                port_free;
    logic                inflight_q;
    bank_idx_t           sel_bank_q;
    par_t                sel_par_q;

    glb_port_map #(
        .NUM_BANK   (NUM_BANK),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_map (
        .cfg_flag_i (cfg_flag_i),
        .cfg_par_i  (cfg_par_i),
        .addr_i     (rd_addr_i),
        .alloc_o    (alloc),
        .hit_bank_o (hit_bank_o),
        .hit_mask_o (hit_mask),
        .range_o    ()
    );

    // ====================
    // Address side
    // ====================
    assign empty_o = rd_addr_i >= bank_wr_level_i[hit_bank_o];

    // One word in flight, a new address may enter as the old data drains
    assign port_free     = ~inflight_q | dat_hs;
    assign rd_addr_rdy_o = alloc & ~empty_o & bank_free_i[hit_bank_o] & port_free;
    assign addr_hs       = rd_addr_vld_i & rd_addr_rdy_o;
    assign bank_ren_o    = hit_mask & {NUM_BANK{addr_hs}};

    // Remember where the pending word lives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight_q <= 1'b0;
            sel_bank_q <= '0;
            sel_par_q  <= '0;
        end else if (addr_hs) begin
            inflight_q <= 1'b1;
            sel_bank_q <= hit_bank_o;
            sel_par_q  <= cfg_par_i;
        end else if (dat_hs) begin
            inflight_q <= 1'b0;
        end
    end

    // ====================
    // Data side
    // ====================
    assign rd_dat_vld_o = inflight_q & bank_rvalid_i[sel_bank_q];
    assign dat_hs       = rd_dat_vld_o & rd_dat_rdy_i;

    // Lanes past par read as zero
    always_comb begin
        int unsigned idx;
        rd_dat_o = '0;
        for (int unsigned k = 0; k < MAXPAR; k++) begin
            idx = int'(sel_bank_q) + k;
            if (k < int'(sel_par_q) && idx < NUM_BANK) begin
                rd_dat_o[k*BANK_WIDTH +: BANK_WIDTH] = bank_rdata_i[idx];
            end
        end
    end

    // Word held by the banks until the consumer takes it
    a_rd_dat_hold : assert property (@(posedge clk) disable iff (!rst_n)
        rd_dat_vld_o && !rd_dat_rdy_i |=> rd_dat_vld_o && $stable(rd_dat_o));

endmodule

`default_nettype wire

//--- glb_bank.sv
`timescale 1ns/1ns
`default_nettype none

module glb_bank
    import glb_pkg::*;
#(
    parameter int NUM_WRPORT = DEF_NUM_WRPORT,
    parameter int NUM_RDPORT = DEF_NUM_RDPORT,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int MAXPAR     = DEF_MAXPAR
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_WRPORT-1:0] wen_i,
    input  logic [NUM_RDPORT-1:0] ren_i,
    input  gaddr_t                wr_addr_i [NUM_WRPORT],
    input  port_data_t            wr_dat_i [NUM_WRPORT],
    input  gaddr_t                rd_addr_i [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_rdy_i,
    input  bank_idx_t             lane_i [NUM_WRPORT],
    output logic                  free_o,
    output logic                  rvalid_o,
    output bank_data_t            rdata_o,
    output gaddr_t                wr_level_o,
    output gaddr_t                rd_level_o
);

    localparam int ROW_W = $clog2(BANK_DEPTH);
    localparam int WP_W  = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1;
    localparam int RP_W  = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1;

    bank_data_t       mem [BANK_DEPTH];

    logic             wen;
    logic [WP_W-1:0]  wsel;
    logic [ROW_W-1:0] wrow;
    bank_data_t       wdata;

    logic             ren;
    logic [RP_W-1:0]  rsel;
    logic [ROW_W-1:0] rrow;
    logic [RP_W-1:0]  rport_q;
    logic             rvalid_q;
    bank_data_t       rdata_q;
    gaddr_t           wr_level_q;
    gaddr_t           rd_level_q;

    // ====================
    // Port selection
    // ====================
    // Lowest index wins
    always_comb begin
        wen  = 1'b0;
        wsel = '0;
        for (int p = NUM_WRPORT - 1; p >= 0; p--) begin
            if (wen_i[p]) begin
                wen  = 1'b1;
                wsel = WP_W'(p);
            end
        end
    end

    always_comb begin
        ren  = 1'b0;
        rsel = '0;
        for (int p = NUM_RDPORT - 1; p >= 0; p--) begin
            if (ren_i[p]) begin
                ren  = 1'b1;
                rsel = RP_W'(p);
            end
        end
    end

    assign wrow = wr_addr_i[wsel][ROW_W-1:0];
    assign rrow = rd_addr_i[rsel][ROW_W-1:0];

    // This bank's lane of the port word
    always_comb begin
        wdata = '0;
        for (int k = 0; k < MAXPAR; k++) begin
            if (int'(lane_i[wsel]) == k) begin
                wdata = wr_dat_i[wsel][k*BANK_WIDTH +: BANK_WIDTH];
            end
        end
    end

    // ====================
    // Storage
    // ====================
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wrow] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ren) begin
            rdata_q <= mem[rrow];
        end
    end

    // Read output register, drained by the port that issued the read
    assign free_o = ~rvalid_q | rd_rdy_i[rport_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rport_q  <= '0;
        end else if (ren) begin
            rvalid_q <= 1'b1;
            rport_q  <= rsel;
        end else if (rd_rdy_i[rport_q]) begin
            rvalid_q <= 1'b0;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // Level registers, one past the last accepted address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_level_q <= '0;
            rd_level_q <= '0;
        end else begin
            if (wen) begin
                wr_level_q <= wr_addr_i[wsel] + 1'b1;
            end
            if (ren) begin
                rd_level_q <= rd_addr_i[rsel] + 1'b1;
            end
        end
    end

    assign wr_level_o = wr_level_q;
    assign rd_level_o = rd_level_q;

    // Bank sets of the write ports never overlap
    a_one_writer : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wen_i));

endmodule

`default_nettype wire

//--- glb_top.sv
`timescale 1ns/1ns
`default_nettype none

module glb_top
    import glb_pkg::*;
#(
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_WRPORT = DEF_NUM_WRPORT,
    parameter int NUM_RDPORT = DEF_NUM_RDPORT,
    parameter int MAXPAR     = DEF_MAXPAR
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Write ports first, then read ports
    input  logic [NUM_BANK-1:0]   cfg_bank_flag_i [NUM_WRPORT+NUM_RDPORT],
    input  par_t                  cfg_par_i [NUM_WRPORT+NUM_RDPORT],
    input  logic [ADDR_WIDTH-1:0] wr_addr_i [NUM_WRPORT],
    input  port_data_t            wr_dat_i [NUM_WRPORT],
    input  logic [NUM_WRPORT-1:0] wr_vld_i,
    output logic [NUM_WRPORT-1:0] wr_rdy_o,
    output logic [NUM_WRPORT-1:0] wr_full_o,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_addr_vld_i,
    output logic [NUM_RDPORT-1:0] rd_addr_rdy_o,
    output logic [NUM_RDPORT-1:0] rd_empty_o,
    output port_data_t            rd_dat_o [NUM_RDPORT],
    output logic [NUM_RDPORT-1:0] rd_dat_vld_o,
    input  logic [NUM_RDPORT-1:0] rd_dat_rdy_i
);

    logic [NUM_BANK-1:0] wr_wen [NUM_WRPORT];
    bank_idx_t           wr_hit [NUM_WRPORT];
    logic [NUM_BANK-1:0] rd_ren [NUM_RDPORT];

    logic [NUM_BANK-1:0] bank_free;
    logic [NUM_BANK-1:0] bank_rvalid;
    bank_data_t          bank_rdata [NUM_BANK];
    gaddr_t              bank_wr_level [NUM_BANK];
    gaddr_t              bank_rd_level [NUM_BANK];

    // ====================
    // Write ports
    // ====================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr
        glb_wr_port #(
            .NUM_BANK   (NUM_BANK),
            .BANK_DEPTH (BANK_DEPTH)
        ) u_wr (
            .wr_vld_i        (wr_vld_i[p]),
            .wr_addr_i       (wr_addr_i[p]),
            .cfg_flag_i      (cfg_bank_flag_i[p]),
            .cfg_par_i       (cfg_par_i[p]),
            .bank_rd_level_i (bank_rd_level),
            .wr_rdy_o        (wr_rdy_o[p]),
            .full_o          (wr_full_o[p]),
            .bank_wen_o      (wr_wen[p]),
            .hit_bank_o      (wr_hit[p])
        );
    end

    // ====================
    // Read ports
    // ====================
    for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rd
        glb_rd_port #(
            .NUM_BANK   (NUM_BANK),
            .BANK_WIDTH (BANK_WIDTH),
            .BANK_DEPTH (BANK_DEPTH),
            .MAXPAR     (MAXPAR)
        ) u_rd (
            .clk             (clk),
            .rst_n           (rst_n),
            .rd_addr_vld_i   (rd_addr_vld_i[p]),
            .rd_addr_i       (rd_addr_i[p]),
            .cfg_flag_i      (cfg_bank_flag_i[NUM_WRPORT+p]),
            .cfg_par_i       (cfg_par_i[NUM_WRPORT+p]),
            .bank_wr_level_i (bank_wr_level),
            .bank_free_i     (bank_free),
            .bank_rvalid_i   (bank_rvalid),
            .bank_rdata_i    (bank_rdata),
            .rd_dat_rdy_i    (rd_dat_rdy_i[p]),
            .rd_addr_rdy_o   (rd_addr_rdy_o[p]),
            .empty_o         (rd_empty_o[p]),
            .bank_ren_o      (rd_ren[p]),
            .rd_dat_o        (rd_dat_o[p]),
            .rd_dat_vld_o    (rd_dat_vld_o[p]),
            .hit_bank_o      ()
        );
    end

    // ====================
    // Banks
    // ====================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic [NUM_WRPORT-1:0] wen;
        logic [NUM_RDPORT-1:0] ren;
        bank_idx_t             lane [NUM_WRPORT];

        for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wsel
            assign wen[p]  = wr_wen[p][b];
            // Offset of this bank inside the port's hit group
            assign lane[p] = bank_idx_t'(b) - wr_hit[p];
        end

        for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rsel
            assign ren[p] = rd_ren[p][b];
        end

        glb_bank #(
            .NUM_WRPORT (NUM_WRPORT),
            .NUM_RDPORT (NUM_RDPORT),
            .BANK_WIDTH (BANK_WIDTH),
            .BANK_DEPTH (BANK_DEPTH),
            .MAXPAR     (MAXPAR)
        ) u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .wen_i      (wen),
            .ren_i      (ren),
            .wr_addr_i  (wr_addr_i),
            .wr_dat_i   (wr_dat_i),
            .rd_addr_i  (rd_addr_i),
            .rd_rdy_i   (rd_dat_rdy_i),
            .lane_i     (lane),
            .free_o     (bank_free[b]),
            .rvalid_o   (bank_rvalid[b]),
            .rdata_o    (bank_rdata[b]),
            .wr_level_o (bank_wr_level[b]),
            .rd_level_o (bank_rd_level[b])
        );
    end

endmodule

`default_nettype wire

//--- tb_glb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_glb_top
    import glb_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst_n;
    logic [7:0] cfg_flag [4];
    par_t       cfg_par [4];
    logic [7:0] wr_addr [2];
    port_data_t wr_dat [2];
    logic [1:0] wr_vld;
    logic [1:0] wr_rdy;
    logic [1:0] wr_full;
    logic [7:0] rd_addr [2];
    logic [1:0] rd_addr_vld;
    logic [1:0] rd_addr_rdy;
    logic [1:0] rd_empty;
    port_data_t rd_dat [2];
    logic [1:0] rd_dat_vld;
    logic [1:0] rd_dat_rdy;

    // Reference words per port, indexed by address mod range
    port_data_t ref_mem [2][64];
    int         wa [2];
    int         ra [2];
    int         errors;
    int         checks;
    logic [31:0] lcg_state;

    glb_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_bank_flag_i (cfg_flag),
        .cfg_par_i       (cfg_par),
        .wr_addr_i       (wr_addr),
        .wr_dat_i        (wr_dat),
        .wr_vld_i        (wr_vld),
        .wr_rdy_o        (wr_rdy),
        .wr_full_o       (wr_full),
        .rd_addr_i       (rd_addr),
        .rd_addr_vld_i   (rd_addr_vld),
        .rd_addr_rdy_o   (rd_addr_rdy),
        .rd_empty_o      (rd_empty),
        .rd_dat_o        (rd_dat),
        .rd_dat_vld_o    (rd_dat_vld),
        .rd_dat_rdy_i    (rd_dat_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Hard limit on the whole run
    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation ran too long and was stopped");
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Port 0 spans banks 0..3 at par 2, port 1 banks 4..7 at par 1
    function automatic int port_range(input int p);
        return (p == 0) ? 32 : 64;
    endfunction

    // Par 1 leaves the upper lane at zero
    function automatic port_data_t expect_word(input int p, input port_data_t d);
        return (p == 0) ? d : {16'h0, d[15:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_word(input int p, input int gap);
        int         waited;
        port_data_t d;
        d = lcg_next();
        repeat (gap) begin
            @(posedge clk);
            wr_vld[p] <= 1'b0;
        end
        @(posedge clk);
        wr_vld[p]  <= 1'b1;
        wr_addr[p] <= 8'(wa[p]);
        wr_dat[p]  <= d;
        waited = 0;
        @(negedge clk);
        while (!wr_rdy[p] && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (wr_rdy[p]) begin
            ref_mem[p][wa[p] % port_range(p)] = expect_word(p, d);
            wa[p]++;
        end else begin
            $display("Write port %0d never became ready at time %0t", p, $time);
            errors++;
        end
    endtask

    task automatic read_word(input int p, input int gap, input int hold);
        int         waited;
        port_data_t exp;
        port_data_t held;
        repeat (gap) begin
            @(posedge clk);
            rd_addr_vld[p] <= 1'b0;
        end
        @(posedge clk);
        rd_addr_vld[p] <= 1'b1;
        rd_addr[p]     <= 8'(ra[p]);
        rd_dat_rdy[p]  <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rd_addr_rdy[p] && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_addr_rdy[p]) begin
            $display("Read port %0d never accepted an address at time %0t", p, $time);
            errors++;
        end else begin
            // Slot cannot be overwritten before this address transfers
            exp = ref_mem[p][ra[p] % port_range(p)];
            ra[p]++;
            check_val($sformatf("rd_dat_vld_o[%0d]", p), rd_dat_vld[p], 1'b0);
            @(posedge clk);
            rd_addr_vld[p] <= 1'b0;
            rd_dat_rdy[p]  <= (hold == 0);
            @(negedge clk);
            check_val($sformatf("rd_dat_vld_o[%0d]", p), rd_dat_vld[p], 1'b1);
            check_val($sformatf("rd_dat_o[%0d]", p), rd_dat[p], exp);
            held = rd_dat[p];
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                if (i == hold - 1) begin
                    rd_dat_rdy[p] <= 1'b1;
                end
                @(negedge clk);
                check_val($sformatf("rd_dat_vld_o[%0d]", p), rd_dat_vld[p], 1'b1);
                check_val($sformatf("rd_dat_o[%0d]", p), rd_dat[p], held);
            end
        end
    endtask

    task automatic port_idle(input int p);
        @(posedge clk);
        wr_vld[p]      <= 1'b0;
        rd_addr_vld[p] <= 1'b0;
        rd_dat_rdy[p]  <= 1'b0;
    endtask

    task automatic stream_writes(input int p, input int n);
        repeat (n) write_word(p, int'(lcg_next() % 3));
        @(posedge clk);
        wr_vld[p] <= 1'b0;
    endtask

    task automatic stream_reads(input int p, input int last);
        while (ra[p] < last) begin
            read_word(p, int'(lcg_next() % 3), int'(lcg_next() % 3));
        end
        @(posedge clk);
        rd_dat_rdy[p] <= 1'b0;
    endtask

    // Fill the ring, see full, then free one slot
    task automatic full_check(input int p);
        while (wa[p] < ra[p] + port_range(p)) begin
            write_word(p, 0);
        end
        @(posedge clk);
        wr_vld[p]  <= 1'b0;
        wr_addr[p] <= 8'(wa[p]);
        @(negedge clk);
        check_val($sformatf("wr_full_o[%0d]", p), wr_full[p], 1'b1);
        check_val($sformatf("wr_rdy_o[%0d]", p), wr_rdy[p], 1'b0);
        read_word(p, 0, 0);
        port_idle(p);
        @(negedge clk);
        check_val($sformatf("wr_full_o[%0d]", p), wr_full[p], 1'b0);
        check_val($sformatf("wr_rdy_o[%0d]", p), wr_rdy[p], 1'b1);
    endtask

    initial begin
        int end0;
        int end1;
        lcg_state   = 32'h7d60;
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        cfg_flag    = '{8'h0f, 8'hf0, 8'h0f, 8'hf0};
        cfg_par     = '{par_t'(2), par_t'(1), par_t'(2), par_t'(1)};
        wr_addr     = '{8'h0, 8'h0};
        wr_dat      = '{32'h0, 32'h0};
        wr_vld      = 2'b00;
        rd_addr     = '{8'h0, 8'h0};
        rd_addr_vld = 2'b00;
        rd_dat_rdy  = 2'b00;
        wa          = '{0, 0};
        ra          = '{0, 0};
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // ====================
        // State after reset
        // ====================
        @(negedge clk);
        check_val("rd_dat_vld_o", rd_dat_vld, 2'b00);
        check_val("rd_empty_o", rd_empty, 2'b11);
        @(posedge clk);
        rd_addr_vld <= 2'b11;
        repeat (4) begin
            @(negedge clk);
            check_val("rd_addr_rdy_o", rd_addr_rdy, 2'b00);
        end
        @(posedge clk);
        rd_addr_vld <= 2'b00;

        // ====================
        // Write then read back
        // ====================
        for (int p = 0; p < 2; p++) begin
            repeat (8) write_word(p, 0);
            port_idle(p);
            repeat (8) read_word(p, 0, 0);
            port_idle(p);
        end

        // Full and its release
        full_check(0);
        full_check(1);

        // Stalled consumer keeps the word
        for (int p = 0; p < 2; p++) begin
            repeat (6) read_word(p, 0, 1 + int'(lcg_next() % 4));
            port_idle(p);
        end

        // ====================
        // Both pairs at once
        // ====================
        end0 = wa[0] + 40;
        end1 = wa[1] + 40;
        fork
            stream_writes(0, 40);
            stream_reads(0, end0);
            stream_writes(1, 40);
            stream_reads(1, end1);
        join
        repeat (4) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
glb_pkg.sv
glb_port_map.sv
glb_wr_port.sv
glb_rd_port.sv
glb_bank.sv
glb_top.sv
tb_glb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; pass is decided from the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_glb_top -f all.f -o sim_glb \
    && ./obj_dir/sim_glb | tee /dev/stderr | grep -q "No errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
